// File: exp_sum_pass.sv
// Pass 1: reads every tile, sums exp(x - max) over all lanes and takes ln of the sum
`timescale 1ns/1ps

module exp_sum_pass #(
    parameter int TOTAL_ELEMENTS = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load_done,
    input  softmax_fmt_pkg::elem_t  max_val,
    output logic                    cyc,
    output logic                    stb,
    output logic                    we,
    output softmax_bus_pkg::addr_t  adr,
    output softmax_fmt_pkg::tile_t  dat_w,
    input  softmax_fmt_pkg::tile_t  dat_r,
    input  logic                    ack,
    output softmax_fmt_pkg::elem_t  ln_sum,
    output softmax_fmt_pkg::elem_t  max_out,
    output logic                    sum_done
);
    import softmax_fmt_pkg::*;
    import softmax_bus_pkg::*;

    localparam int NUM_TILES = TOTAL_ELEMENTS / TILE_SIZE;

    typedef enum logic [2:0] {S_IDLE, S_READ, S_GAP, S_LN_WAIT, S_DONE} sum_state_e;

    sum_state_e state;
    sum_t       sum;
    sum_t       tile_sum;             // Exponentials of the tile on dat_r
    elem_t      exp_y [TILE_SIZE];

    for (genvar i = 0; i < TILE_SIZE; i++) begin : g_lane
        exp_unit u_exp (
            .x (get_lane(dat_r, i) - max_out),
            .y (exp_y[i])
        );
    end

    always_comb begin
        tile_sum = '0;
        for (int i = 0; i < TILE_SIZE; i++) begin
            tile_sum = tile_sum + sum_t'($unsigned(exp_y[i]));
        end
    end

    // Follows the sum one cycle later
    ln_unit u_ln (
        .clk   (clk),
        .rst_n (rst_n),
        .s     (sum),
        .ln    (ln_sum)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            adr     <= '0;
            sum     <= '0;
            max_out <= '0;
        end else begin
            case (state)
                S_IDLE: if (load_done) begin
                    max_out <= max_val;
                    sum     <= '0;
                    adr     <= '0;
                    state   <= S_READ;
                end
                S_READ: if (ack) begin
                    sum   <= sum + tile_sum;
                    adr   <= adr + 1'b1;
                    state <= (adr == addr_t'(NUM_TILES - 1)) ? S_LN_WAIT : S_GAP;
                end
                S_GAP:     state <= S_READ;    // cyc low for one cycle
                S_LN_WAIT: state <= S_DONE;    // ln_unit registers the final sum
                default:   state <= S_IDLE;
            endcase
        end
    end

    assign cyc      = (state == S_READ);
    assign stb      = cyc;
    assign we       = 1'b0;
    assign dat_w    = '0;
    assign sum_done = (state == S_DONE);

endmodule

// File: exp_unit.sv
// Combinational base-2 exponential of one non-positive Q16.16 lane, one per lane in a pass
`timescale 1ns/1ps

module exp_unit (
    input  softmax_fmt_pkg::elem_t x,
    output softmax_fmt_pkg::elem_t y
);
    import softmax_fmt_pkg::*;

    logic signed [63:0] prod;    // x * log2(e) in Q32.32
    logic signed [63:0] t;       // Same in Q16.16
    logic signed [63:0] neg_n;   // Minus the integer part, i.e. the right shift
    elem_t              mant;    // 1.f in Q16.16

    assign prod = x * LOG2E_Q;
    assign t    = prod >>> FRAC_WIDTH;

    // Arithmetic shift floors, t is never positive
    assign neg_n = -(t >>> FRAC_WIDTH);
    assign mant  = ELEM_WIDTH'({1'b1, t[FRAC_WIDTH-1:0]});

    // 2^n * 1.f, flushed to zero once the shift empties the word
    assign y = (neg_n >= 32) ? '0 : (mant >> neg_n[4:0]);

endmodule

// File: list.f
softmax_fmt_pkg.sv
softmax_bus_pkg.sv
exp_unit.sv
ln_unit.sv
shared_tile_buffer.sv
tile_loader.sv
exp_sum_pass.sv
normalize_pass.sv
softmax_top.sv
softmax_checker.sv
tb_softmax.sv

// File: ln_unit.sv
// Registered natural log of the exponential sum, by leading-one range reduction; used in pass 1
`timescale 1ns/1ps

module ln_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  softmax_fmt_pkg::sum_t  s,
    output softmax_fmt_pkg::elem_t ln
);
    import softmax_fmt_pkg::*;

    logic [5:0]         p;       // Leading one position
    logic signed [63:0] k;       // Integer part of log2(s)
    sum_t               norm;    // s with its leading one moved to bit FRAC_WIDTH
    logic signed [63:0] log2_q;  // k + m in Q16.16
    logic signed [63:0] prod;

    always_comb begin
        p = '0;
        for (int i = 0; i < SUM_WIDTH; i++) begin
            if (s[i]) begin
                p = 6'(i);
            end
        end
    end

    assign k = $signed({58'b0, p}) - FRAC_WIDTH;

    // Zero-fill on the right when the sum is below one
    assign norm = (p >= FRAC_WIDTH) ? (s >> (p - FRAC_WIDTH)) : (s << (FRAC_WIDTH - p));

    assign log2_q = (k <<< FRAC_WIDTH) + $signed({48'b0, norm[FRAC_WIDTH-1:0]});
    assign prod   = log2_q * LN2_Q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ln <= '0;
        end else begin
            ln <= elem_t'(prod >>> FRAC_WIDTH);   // ln(s) = log2(s) * ln(2)
        end
    end

endmodule

// File: normalize_pass.sv
// Pass 2: reads every tile again and streams out exp(x - max - ln_sum) tiles
`timescale 1ns/1ps

module normalize_pass #(
    parameter int TOTAL_ELEMENTS = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sum_done,
    input  softmax_fmt_pkg::elem_t  ln_sum,
    input  softmax_fmt_pkg::elem_t  max_val,
    output logic                    cyc,
    output logic                    stb,
    output logic                    we,
    output softmax_bus_pkg::addr_t  adr,
    output softmax_fmt_pkg::tile_t  dat_w,
    input  softmax_fmt_pkg::tile_t  dat_r,
    input  logic                    ack,
    output softmax_fmt_pkg::tile_t  tile_out,
    output logic                    tile_out_valid,
    input  logic                    tile_out_ready,
    output logic                    done
);
    import softmax_fmt_pkg::*;
    import softmax_bus_pkg::*;

    localparam int NUM_TILES = TOTAL_ELEMENTS / TILE_SIZE;

    typedef enum logic [1:0] {N_IDLE, N_READ, N_OUT, N_DONE} norm_state_e;

    norm_state_e state;
    elem_t       max_q;
    elem_t       ln_q;
    tile_t       out_next;

    for (genvar i = 0; i < TILE_SIZE; i++) begin : g_lane
        exp_unit u_exp (
            .x (get_lane(dat_r, i) - max_q - ln_q),
            .y (out_next[(TILE_SIZE-1-i)*ELEM_WIDTH +: ELEM_WIDTH])
        );
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= N_IDLE;
            adr   <= '0;
            max_q <= '0;
            ln_q  <= '0;
        end else begin
            case (state)
                N_IDLE: if (sum_done) begin
                    max_q <= max_val;
                    ln_q  <= ln_sum;
                    adr   <= '0;
                    state <= N_READ;
                end
                N_READ: if (ack) begin
                    state <= N_OUT;
                end
                N_OUT: if (tile_out_ready) begin
                    // Next read only once the current tile is taken
                    adr   <= adr + 1'b1;
                    state <= (adr == addr_t'(NUM_TILES - 1)) ? N_DONE : N_READ;
                end
                default: state <= N_IDLE;
            endcase
        end
    end

    // Result tile, held through back-pressure
    always_ff @(posedge clk) begin
        if (state == N_READ && ack) begin
            tile_out <= out_next;
        end
    end

    assign cyc            = (state == N_READ);
    assign stb            = cyc;
    assign we             = 1'b0;
    assign dat_w          = '0;
    assign tile_out_valid = (state == N_OUT);
    assign done           = (state == N_DONE);

endmodule

// File: run.sh
#!/bin/sh
# Builds and runs the softmax testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module tb_softmax -o sim_softmax &&
./obj_dir/sim_softmax | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }

// File: shared_tile_buffer.sv
// Tile memory behind a fixed-priority Wishbone classic arbiter for the three pass engines
`timescale 1ns/1ps

module shared_tile_buffer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    m0_cyc,
    input  logic                    m0_stb,
    input  logic                    m0_we,
    input  softmax_bus_pkg::addr_t  m0_adr,
    input  softmax_fmt_pkg::tile_t  m0_dat_w,
    output softmax_fmt_pkg::tile_t  m0_dat_r,
    output logic                    m0_ack,
    input  logic                    m1_cyc,
    input  logic                    m1_stb,
    input  logic                    m1_we,
    input  softmax_bus_pkg::addr_t  m1_adr,
    input  softmax_fmt_pkg::tile_t  m1_dat_w,
    output softmax_fmt_pkg::tile_t  m1_dat_r,
    output logic                    m1_ack,
    input  logic                    m2_cyc,
    input  logic                    m2_stb,
    input  logic                    m2_we,
    input  softmax_bus_pkg::addr_t  m2_adr,
    input  softmax_fmt_pkg::tile_t  m2_dat_w,
    output softmax_fmt_pkg::tile_t  m2_dat_r,
    output logic                    m2_ack
);
    import softmax_fmt_pkg::*;
    import softmax_bus_pkg::*;

    logic [NUM_MASTERS-1:0] cyc_v;
    logic [NUM_MASTERS-1:0] stb_v;
    logic [NUM_MASTERS-1:0] we_v;
    addr_t                  adr_v   [NUM_MASTERS];
    tile_t                  dat_w_v [NUM_MASTERS];

    master_id_e gnt_id;
    master_id_e next_id;
    logic       gnt_valid;
    logic       req;        // Granted master has a strobe not yet acked
    logic       ack_q;
    tile_t      rd_q;
    tile_t      mem [MAX_TILES];

    assign cyc_v   = {m2_cyc, m1_cyc, m0_cyc};
    assign stb_v   = {m2_stb, m1_stb, m0_stb};
    assign we_v    = {m2_we, m1_we, m0_we};
    assign adr_v   = '{m0_adr, m1_adr, m2_adr};
    assign dat_w_v = '{m0_dat_w, m1_dat_w, m2_dat_w};

    // Lowest-numbered requester
    always_comb begin
        next_id = LOADER;
        for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
            if (cyc_v[i]) begin
                next_id = master_id_e'(i);
            end
        end
    end

    assign req = gnt_valid && cyc_v[gnt_id] && stb_v[gnt_id] && !ack_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gnt_valid <= 1'b0;
            gnt_id    <= LOADER;
            ack_q     <= 1'b0;
        end else begin
            if (!gnt_valid) begin
                if (|cyc_v) begin
                    gnt_valid <= 1'b1;
                    gnt_id    <= next_id;
                end
            end else if (!cyc_v[gnt_id]) begin
                gnt_valid <= 1'b0;   // Held cycle is over
            end
            ack_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            if (we_v[gnt_id]) begin
                mem[adr_v[gnt_id]] <= dat_w_v[gnt_id];
            end
            rd_q <= mem[adr_v[gnt_id]];
        end
    end

    // Read data is shared, ack goes only to the granted master
    assign m0_dat_r = rd_q;
    assign m1_dat_r = rd_q;
    assign m2_dat_r = rd_q;
    assign m0_ack   = ack_q && (gnt_id == LOADER);
    assign m1_ack   = ack_q && (gnt_id == SUM_PASS);
    assign m2_ack   = ack_q && (gnt_id == NORM_PASS);

endmodule

// File: softmax_bus_pkg.sv
// Tile buffer bus definitions; shared by the buffer arbiter and its three bus masters
package softmax_bus_pkg;

    localparam int MAX_TILES   = 16;
    localparam int NUM_MASTERS = 3;

    typedef logic [$clog2(MAX_TILES)-1:0] addr_t;

    // Lower value wins arbitration
    typedef enum logic [1:0] {
        LOADER    = 2'd0,
        SUM_PASS  = 2'd1,
        NORM_PASS = 2'd2
    } master_id_e;

endpackage

// File: softmax_checker.sv
// Concurrent protocol assertions for the softmax streams and buffer bus; bound into softmax_top
`timescale 1ns/1ps

module softmax_checker (
    input logic                   clk,
    input logic                   rst_n,
    input softmax_fmt_pkg::tile_t tile_in,
    input logic                   tile_in_valid,
    input logic                   tile_in_ready,
    input softmax_fmt_pkg::tile_t tile_out,
    input logic                   tile_out_valid,
    input logic                   tile_out_ready,
    input logic                   done,
    input logic                   m0_cyc,
    input logic                   m0_stb,
    input softmax_bus_pkg::addr_t m0_adr,
    input softmax_fmt_pkg::tile_t m0_dat_w,
    input logic                   m0_ack,
    input logic                   m1_cyc,
    input logic                   m1_stb,
    input softmax_bus_pkg::addr_t m1_adr,
    input logic                   m1_ack,
    input logic                   m2_cyc,
    input logic                   m2_stb,
    input softmax_bus_pkg::addr_t m2_adr,
    input logic                   m2_ack
);
    // Streams hold valid and data until taken
    in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        tile_in_valid && !tile_in_ready |=> tile_in_valid && $stable(tile_in))
        else $error("input stream dropped or changed a pending tile");
    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        tile_out_valid && !tile_out_ready |=> tile_out_valid && $stable(tile_out))
        else $error("output stream dropped or changed a pending tile");

    // Bus requests stay put until ack
    m0_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m0_stb && !m0_ack |=> m0_stb && $stable(m0_adr) && $stable(m0_dat_w))
        else $error("loader bus request changed before ack");
    m1_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m1_stb && !m1_ack |=> m1_stb && $stable(m1_adr))
        else $error("sum pass bus request changed before ack");
    m2_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m2_stb && !m2_ack |=> m2_stb && $stable(m2_adr))
        else $error("normalize pass bus request changed before ack");

    m0_ack_cyc: assert property (@(posedge clk) disable iff (!rst_n) m0_ack |-> m0_cyc)
        else $error("ack to loader without cyc");
    m1_ack_cyc: assert property (@(posedge clk) disable iff (!rst_n) m1_ack |-> m1_cyc)
        else $error("ack to sum pass without cyc");
    m2_ack_cyc: assert property (@(posedge clk) disable iff (!rst_n) m2_ack |-> m2_cyc)
        else $error("ack to normalize pass without cyc");

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done held longer than one cycle");

endmodule

bind softmax_top softmax_checker u_softmax_checker (
    .clk            (clk),
    .rst_n          (rst_n),
    .tile_in        (tile_in),
    .tile_in_valid  (tile_in_valid),
    .tile_in_ready  (tile_in_ready),
    .tile_out       (tile_out),
    .tile_out_valid (tile_out_valid),
    .tile_out_ready (tile_out_ready),
    .done           (done),
    .m0_cyc         (m0_cyc),
    .m0_stb         (m0_stb),
    .m0_adr         (m0_adr),
    .m0_dat_w       (m0_dat_w),
    .m0_ack         (m0_ack),
    .m1_cyc         (m1_cyc),
    .m1_stb         (m1_stb),
    .m1_adr         (m1_adr),
    .m1_ack         (m1_ack),
    .m2_cyc         (m2_cyc),
    .m2_stb         (m2_stb),
    .m2_adr         (m2_adr),
    .m2_ack         (m2_ack)
);

// File: softmax_fmt_pkg.sv
// Number formats of the softmax datapath; imported by the exp, ln and pass modules
package softmax_fmt_pkg;

    localparam int ELEM_WIDTH = 32;
    localparam int FRAC_WIDTH = 16;
    localparam int TILE_SIZE  = 4;
    localparam int SUM_WIDTH  = 38;   // Room for 64 exponentials of at most 1.0

    // Signed Q16.16 element
    typedef logic signed [ELEM_WIDTH-1:0] elem_t;

    // Unsigned Q22.16 running sum
    typedef logic [SUM_WIDTH-1:0] sum_t;

    // Lane 0 in the most significant slot
    typedef logic [TILE_SIZE*ELEM_WIDTH-1:0] tile_t;

    localparam elem_t LOG2E_Q  = 32'sd94548;        // 1.442695
    localparam elem_t LN2_Q    = 32'sd45426;        // 0.693147
    localparam elem_t ELEM_MIN = 32'sh8000_0000;    // Start value of the running max

    // Pick one lane out of a tile
    function automatic elem_t get_lane(tile_t t, int idx);
        return elem_t'(t[(TILE_SIZE-1-idx)*ELEM_WIDTH +: ELEM_WIDTH]);
    endfunction

endpackage

// File: softmax_stim.txt
# I = input tile, E = expected output tile; four hex Q16.16 lanes each, lane 0 first
# Three vectors of four tiles, inputs of a vector before its expected outputs
# Vector 1: +1.0 and -1.0
I 00010000 FFFF0000 FFFF0000 FFFF0000
I FFFF0000 FFFF0000 00010000 FFFF0000
I FFFF0000 00010000 FFFF0000 FFFF0000
I FFFF0000 FFFF0000 FFFF0000 00010000
E 000032A0 000006C9 000006C9 000006C9
E 000006C9 000006C9 000032A0 000006C9
E 000006C9 000032A0 000006C9 000006C9
E 000006C9 000006C9 000006C9 000032A0
# Vector 2: all 100.0
I 00640000 00640000 00640000 00640000
I 00640000 00640000 00640000 00640000
I 00640000 00640000 00640000 00640000
I 00640000 00640000 00640000 00640000
E 00001000 00001000 00001000 00001000
E 00001000 00001000 00001000 00001000
E 00001000 00001000 00001000 00001000
E 00001000 00001000 00001000 00001000
# Vector 3: 3.0 and 1.0
I 00010000 00010000 00010000 00010000
I 00030000 00010000 00030000 00010000
I 00010000 00010000 00010000 00010000
I 00010000 00030000 00010000 00030000
E 000006C9 000006C9 000006C9 000006C9
E 000032A0 000006C9 000032A0 000006C9
E 000006C9 000006C9 000006C9 000006C9
E 000006C9 000032A0 000006C9 000032A0

// File: softmax_top.sv
// Softmax top level; wires the load, sum and normalize passes to the shared tile buffer
`timescale 1ns/1ps

module softmax_top #(
    parameter int TOTAL_ELEMENTS = 16   // Multiple of TILE_SIZE, at most MAX_TILES tiles
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  softmax_fmt_pkg::tile_t  tile_in,
    input  logic                    tile_in_valid,
    output logic                    tile_in_ready,
    output softmax_fmt_pkg::tile_t  tile_out,
    output logic                    tile_out_valid,
    input  logic                    tile_out_ready,
    output logic                    done
);
    import softmax_fmt_pkg::*;
    import softmax_bus_pkg::*;

    // Bus master 0, the loader
    logic  m0_cyc, m0_stb, m0_we, m0_ack;
    addr_t m0_adr;
    tile_t m0_dat_w;

    // Bus master 1, the sum pass
    logic  m1_cyc, m1_stb, m1_we, m1_ack;
    addr_t m1_adr;
    tile_t m1_dat_w, m1_dat_r;

    // Bus master 2, the normalize pass
    logic  m2_cyc, m2_stb, m2_we, m2_ack;
    addr_t m2_adr;
    tile_t m2_dat_w, m2_dat_r;

    elem_t load_max;
    logic  load_done;
    elem_t sum_max;
    elem_t ln_sum;
    logic  sum_done;

    tile_loader #(.TOTAL_ELEMENTS(TOTAL_ELEMENTS)) u_tile_loader (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .tile_in       (tile_in),
        .tile_in_valid (tile_in_valid),
        .tile_in_ready (tile_in_ready),
        .cyc           (m0_cyc),
        .stb           (m0_stb),
        .we            (m0_we),
        .adr           (m0_adr),
        .dat_w         (m0_dat_w),
        .ack           (m0_ack),
        .max_val       (load_max),
        .load_done     (load_done)
    );

    exp_sum_pass #(.TOTAL_ELEMENTS(TOTAL_ELEMENTS)) u_exp_sum_pass (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_done (load_done),
        .max_val   (load_max),
        .cyc       (m1_cyc),
        .stb       (m1_stb),
        .we        (m1_we),
        .adr       (m1_adr),
        .dat_w     (m1_dat_w),
        .dat_r     (m1_dat_r),
        .ack       (m1_ack),
        .ln_sum    (ln_sum),
        .max_out   (sum_max),
        .sum_done  (sum_done)
    );

    normalize_pass #(.TOTAL_ELEMENTS(TOTAL_ELEMENTS)) u_normalize_pass (
        .clk            (clk),
        .rst_n          (rst_n),
        .sum_done       (sum_done),
        .ln_sum         (ln_sum),
        .max_val        (sum_max),
        .cyc            (m2_cyc),
        .stb            (m2_stb),
        .we             (m2_we),
        .adr            (m2_adr),
        .dat_w          (m2_dat_w),
        .dat_r          (m2_dat_r),
        .ack            (m2_ack),
        .tile_out       (tile_out),
        .tile_out_valid (tile_out_valid),
        .tile_out_ready (tile_out_ready),
        .done           (done)
    );

    // The loader only writes, so its read data stays open
    shared_tile_buffer u_shared_tile_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .m0_cyc   (m0_cyc),
        .m0_stb   (m0_stb),
        .m0_we    (m0_we),
        .m0_adr   (m0_adr),
        .m0_dat_w (m0_dat_w),
        .m0_dat_r (),
        .m0_ack   (m0_ack),
        .m1_cyc   (m1_cyc),
        .m1_stb   (m1_stb),
        .m1_we    (m1_we),
        .m1_adr   (m1_adr),
        .m1_dat_w (m1_dat_w),
        .m1_dat_r (m1_dat_r),
        .m1_ack   (m1_ack),
        .m2_cyc   (m2_cyc),
        .m2_stb   (m2_stb),
        .m2_we    (m2_we),
        .m2_adr   (m2_adr),
        .m2_dat_w (m2_dat_w),
        .m2_dat_r (m2_dat_r),
        .m2_ack   (m2_ack)
    );

endmodule

// File: tb_softmax.sv
// Softmax testbench; reads tiles from softmax_stim.txt, runs the vectors and checks the outputs
`timescale 1ns/1ps

module tb_softmax;
    import softmax_fmt_pkg::*;

    localparam int TOTAL_ELEMENTS = 16;
    localparam int TILES_PER_VEC  = TOTAL_ELEMENTS / TILE_SIZE;
    localparam int NUM_VECTORS    = 3;
    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 16;
    localparam int WATCHDOG_NS    = RESET_CYCLES * CLK_PERIOD + NUM_VECTORS * 200 * CLK_PERIOD;
    localparam int DONE_WINDOW    = 8;      // Cycles watched for done after the last tile

    logic  clk;
    logic  rst_n;
    logic  start;
    tile_t tile_in;
    logic  tile_in_valid;
    logic  tile_in_ready;
    tile_t tile_out;
    logic  tile_out_valid;
    logic  tile_out_ready;
    logic  done;

    tile_t in_tiles[$];
    tile_t exp_tiles[$];
    int    errors;
    int    tests_passed;
    int    tests_failed;

    softmax_top #(.TOTAL_ELEMENTS(TOTAL_ELEMENTS)) u_softmax_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .tile_in        (tile_in),
        .tile_in_valid  (tile_in_valid),
        .tile_in_ready  (tile_in_ready),
        .tile_out       (tile_out),
        .tile_out_valid (tile_out_valid),
        .tile_out_ready (tile_out_ready),
        .done           (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    // Parses I and E lines into the tile queues
    task automatic load_stim(output bit ok);
        int         fd;
        int         n;
        string      line;
        logic [7:0] kind;
        elem_t      l0, l1, l2, l3;
        fd = $fopen("softmax_stim.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 2 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h %h %h", kind, l0, l1, l2, l3);
                    if (n == 5 && kind == "I") in_tiles.push_back({l0, l1, l2, l3});
                    if (n == 5 && kind == "E") exp_tiles.push_back({l0, l1, l2, l3});
                end
            end
            $fclose(fd);
            ok = (in_tiles.size() == NUM_VECTORS * TILES_PER_VEC) &&
                 (exp_tiles.size() == NUM_VECTORS * TILES_PER_VEC);
        end
    endtask

    task automatic check_idle_outputs(input string phase);
        assert (tile_in_ready === 1'b0 && tile_out_valid === 1'b0 && done === 1'b0) else begin
            $display("FAILED at %0t ns: outputs not low %s (ready %b valid %b done %b)",
                     $time, phase, tile_in_ready, tile_out_valid, done);
            errors++;
        end
    endtask

    task automatic send_tiles(input int vec, input bit rand_mode);
        bit hs;
        int gap;
        for (int i = 0; i < TILES_PER_VEC; i++) begin
            gap = rand_mode ? $urandom_range(0, 3) : 0;
            repeat (gap) begin
                @(posedge clk);
                #0.5;
            end
            tile_in       = in_tiles[vec * TILES_PER_VEC + i];
            tile_in_valid = 1'b1;
            do begin
                @(negedge clk);
                hs = tile_in_ready;   // Transfer happens on the coming edge
                @(posedge clk);
                #0.5;
            end while (!hs);
            tile_in_valid = 1'b0;
        end
    endtask

    task automatic collect_tiles(input int vec, input bit rand_mode);
        int    got;
        int    done_cnt;
        tile_t expected;
        got      = 0;
        done_cnt = 0;
        while (got < TILES_PER_VEC) begin
            tile_out_ready = rand_mode ? ($urandom_range(0, 3) != 0) : 1'b1;
            @(negedge clk);
            if (done) done_cnt++;
            if (tile_out_valid && tile_out_ready) begin
                expected = exp_tiles[vec * TILES_PER_VEC + got];
                assert (tile_out === expected) else begin
                    $display("FAILED at %0t ns: vector %0d tile %0d got %h expected %h",
                             $time, vec + 1, got, tile_out, expected);
                    errors++;
                end
                got++;
            end
            @(posedge clk);
            #0.5;
        end
        assert (done_cnt == 0) else begin
            $display("FAILED at %0t ns: done before the last tile of vector %0d", $time, vec + 1);
            errors++;
        end
        tile_out_ready = 1'b1;
        repeat (DONE_WINDOW) begin
            @(negedge clk);
            if (done) done_cnt++;
            assert (!tile_out_valid) else begin
                $display("FAILED at %0t ns: extra output tile after vector %0d", $time, vec + 1);
                errors++;
            end
        end
        assert (done_cnt == 1) else begin
            $display("FAILED at %0t ns: vector %0d saw %0d done pulses, expected 1",
                     $time, vec + 1, done_cnt);
            errors++;
        end
    endtask

    task automatic run_vector(input int vec, input bit rand_mode);
        @(posedge clk);
        #0.5;
        start = 1'b1;
        @(posedge clk);
        #0.5;
        start = 1'b0;
        fork
            send_tiles(vec, rand_mode);
            collect_tiles(vec, rand_mode);
        join
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", name, errors - errs_before);
        end
    endtask

    initial begin
        bit ok;
        int mark;
        void'($urandom(32'h8663_e498));
        errors         = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        rst_n          = 1'b0;
        start          = 1'b0;
        tile_in        = '0;
        tile_in_valid  = 1'b0;
        tile_out_ready = 1'b0;

        load_stim(ok);

        mark = errors;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle_outputs("during reset");
        end
        @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs("after reset");
        end
        report_test("reset", mark);

        if (ok) begin
            mark = errors;
            run_vector(0, 1'b0);
            report_test("basic vector", mark);

            mark = errors;
            run_vector(1, 1'b0);
            report_test("max subtraction", mark);

            mark = errors;
            run_vector(2, 1'b1);
            report_test("back-pressure", mark);

            // Vector 3 right after the larger maximum of vector 2
            mark = errors;
            run_vector(1, 1'b0);
            run_vector(2, 1'b0);
            report_test("back-to-back runs", mark);
        end else begin
            $display("ERROR: stimulus file softmax_stim.txt missing or incomplete");
            errors++;
            tests_failed++;
        end

        $display("Tests: %0d passed, %0d failed, %0d check errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tile_loader.sv
// Pass 0: takes input tiles, writes them to the tile buffer and tracks the vector maximum
`timescale 1ns/1ps

module tile_loader #(
    parameter int TOTAL_ELEMENTS = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  softmax_fmt_pkg::tile_t  tile_in,
    input  logic                    tile_in_valid,
    output logic                    tile_in_ready,
    output logic                    cyc,
    output logic                    stb,
    output logic                    we,
    output softmax_bus_pkg::addr_t  adr,
    output softmax_fmt_pkg::tile_t  dat_w,
    input  logic                    ack,
    output softmax_fmt_pkg::elem_t  max_val,
    output logic                    load_done
);
    import softmax_fmt_pkg::*;
    import softmax_bus_pkg::*;

    localparam int NUM_TILES = TOTAL_ELEMENTS / TILE_SIZE;

    typedef enum logic [1:0] {L_IDLE, L_TAKE, L_WRITE, L_FINISH} load_state_e;

    load_state_e state;
    elem_t       tile_max;   // Running max folded with the incoming tile

    always_comb begin
        tile_max = max_val;
        for (int i = 0; i < TILE_SIZE; i++) begin
            if (get_lane(tile_in, i) > tile_max) begin
                tile_max = get_lane(tile_in, i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= L_IDLE;
            adr     <= '0;
            max_val <= ELEM_MIN;
        end else begin
            case (state)
                L_IDLE: if (start) begin
                    state   <= L_TAKE;
                    adr     <= '0;
                    max_val <= ELEM_MIN;
                end
                L_TAKE: if (tile_in_valid) begin
                    max_val <= tile_max;
                    state   <= L_WRITE;
                end
                L_WRITE: if (ack) begin
                    adr   <= adr + 1'b1;
                    state <= (adr == addr_t'(NUM_TILES - 1)) ? L_FINISH : L_TAKE;
                end
                default: state <= L_IDLE;   // L_FINISH lasts one cycle
            endcase
        end
    end

    // Payload register, written with the accepted tile
    always_ff @(posedge clk) begin
        if (state == L_TAKE && tile_in_valid) begin
            dat_w <= tile_in;
        end
    end

    assign tile_in_ready = (state == L_TAKE);
    assign cyc           = (state == L_WRITE);
    assign stb           = cyc;
    assign we            = 1'b1;
    assign load_done     = (state == L_FINISH);

endmodule
